/* hdl/exec_pkg.sv */
package exec_pkg;

  // datapath width shared by both units and the output arbiter
  localparam int XLEN = 64;

  // destination register number width
  localparam int RD_W = 4;

  // opcodes, alu ops first and then the multiplier ops
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SLT   = 4'd7,
    // low half of the unsigned product
    OP_MUL   = 4'd8,
    // high half of the unsigned product
    OP_MULHU = 4'd9
  } exec_op_e;

  // memory operation for the next stage, carried through the units untouched
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // 10-bit command word that travels with every operation
  typedef struct packed {
    exec_op_e         op;
    mem_op_e          mem_op;
    logic [RD_W-1:0]  rd;
  } exec_cmd_t;

  // condition flags of a finished result
  typedef struct packed {
    logic zero;
    logic negative;
    // add gives the carry out, sub gives the adder carry (1 means no borrow)
    logic carry;
    logic overflow;
  } exec_flags_t;

endpackage

/* hdl/exec_result_if.sv */
interface exec_result_if #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
);
  import exec_pkg::*;

  // finished result offered by a unit
  logic              valid;
  logic [XLEN-1:0]   data;
  logic [TAG_W-1:0]  tag;
  exec_cmd_t         cmd;
  exec_flags_t       flags;

  // grant back from the arbiter, unit holds its fields while valid && !can_go
  logic              can_go;

  // execution unit side
  modport unit (
    output valid, data, tag, cmd, flags,
    input  can_go
  );

  // arbiter side
  modport arbiter (
    input  valid, data, tag, cmd, flags,
    output can_go
  );

endinterface

/* hdl/alu_unit.sv */
module alu_unit #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  exec_pkg::exec_cmd_t        cmd_i,
  input  logic [exec_pkg::XLEN-1:0]  a_i,
  input  logic [exec_pkg::XLEN-1:0]  b_i,
  input  logic [TAG_W-1:0]           tag_i,
  output logic                       ready_o,
  exec_result_if.unit                res_o
);
  import exec_pkg::*;

  // shift amount is the low bits of b
  localparam int SHAMT_W = $clog2(XLEN);

  logic              is_sub;
  logic [XLEN-1:0]   addend;
  logic [XLEN:0]     sum_ext;
  logic [XLEN-1:0]   result;
  exec_flags_t       flags;
  logic              take;

  // holding register toward the arbiter
  logic              full_q;
  logic [XLEN-1:0]   data_q;
  logic [TAG_W-1:0]  tag_q;
  exec_cmd_t         cmd_q;
  exec_flags_t       flags_q;

  // one adder for add and sub, sub is a + ~b + 1
  assign is_sub  = (cmd_i.op == OP_SUB);
  assign addend  = is_sub ? ~b_i : b_i;
  assign sum_ext = {1'b0, a_i} + {1'b0, addend} + {{XLEN{1'b0}}, is_sub};

  always_comb begin
    result         = '0;
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (cmd_i.op)
      OP_ADD, OP_SUB: begin
        result         = sum_ext[XLEN-1:0];
        flags.carry    = sum_ext[XLEN];
        // operands of equal sign giving a result of the other sign
        flags.overflow = (a_i[XLEN-1] == addend[XLEN-1]) &&
                         (result[XLEN-1] != a_i[XLEN-1]);
      end
      OP_AND:  result = a_i & b_i;
      OP_OR:   result = a_i | b_i;
      OP_XOR:  result = a_i ^ b_i;
      OP_SLL:  result = a_i << b_i[SHAMT_W-1:0];
      OP_SRL:  result = a_i >> b_i[SHAMT_W-1:0];
      // signed compare, result is 1 or 0
      OP_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
      default: result = '0;
    endcase
    flags.zero     = (result == '0);
    flags.negative = result[XLEN-1];
  end

  // room when empty or when the held result leaves this cycle
  assign ready_o = !full_q || res_o.can_go;
  assign take    = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (res_o.can_go) begin
      full_q <= 1'b0;
    end
  end

  // payload only loads on issue, so an ungranted result stays put
  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q  <= result;
      tag_q   <= tag_i;
      cmd_q   <= cmd_i;
      flags_q <= flags;
    end
  end

  assign res_o.valid = full_q;
  assign res_o.data  = data_q;
  assign res_o.tag   = tag_q;
  assign res_o.cmd   = cmd_q;
  assign res_o.flags = flags_q;

endmodule

/* hdl/mul_unit.sv */
module mul_unit #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  exec_pkg::exec_cmd_t        cmd_i,
  input  logic [exec_pkg::XLEN-1:0]  a_i,
  input  logic [exec_pkg::XLEN-1:0]  b_i,
  input  logic [TAG_W-1:0]           tag_i,
  output logic                       ready_o,
  exec_result_if.unit                res_o
);
  import exec_pkg::*;

  localparam int HALF = XLEN / 2;

  logic                advance;
  logic                take;
  logic [XLEN-1:0]     a_lo, a_hi, b_lo, b_hi;
  logic [XLEN-1:0]     s3_result;

  // stage 1 holds the four half-width partial products
  logic                s1_valid_q;
  logic [XLEN-1:0]     pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic [TAG_W-1:0]    s1_tag_q;
  exec_cmd_t           s1_cmd_q;

  // stage 2 holds the full 2*XLEN product
  logic                s2_valid_q;
  logic [2*XLEN-1:0]   prod_q;
  logic [TAG_W-1:0]    s2_tag_q;
  exec_cmd_t           s2_cmd_q;

  // stage 3 holds the selected half and its flags
  logic                s3_valid_q;
  logic [XLEN-1:0]     s3_data_q;
  exec_flags_t         s3_flags_q;
  logic [TAG_W-1:0]    s3_tag_q;
  exec_cmd_t           s3_cmd_q;

  // whole pipe freezes while the last stage waits for a grant
  assign advance = !(s3_valid_q && !res_o.can_go);
  assign ready_o = advance;
  assign take    = valid_i && ready_o;

  // zero-extended halves keep every partial product XLEN wide
  assign a_lo = {{HALF{1'b0}}, a_i[HALF-1:0]};
  assign a_hi = {{HALF{1'b0}}, a_i[XLEN-1:HALF]};
  assign b_lo = {{HALF{1'b0}}, b_i[HALF-1:0]};
  assign b_hi = {{HALF{1'b0}}, b_i[XLEN-1:HALF]};

  assign s3_result = (s2_cmd_q.op == OP_MULHU) ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s3_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= take;
      s2_valid_q <= s1_valid_q;
      s3_valid_q <= s2_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      pp_ll_q  <= a_lo * b_lo;
      pp_lh_q  <= a_lo * b_hi;
      pp_hl_q  <= a_hi * b_lo;
      pp_hh_q  <= a_hi * b_hi;
      s1_tag_q <= tag_i;
      s1_cmd_q <= cmd_i;
      // cross terms sit one half-word up
      prod_q   <= {pp_hh_q, pp_ll_q} +
                  {{HALF{1'b0}}, pp_lh_q, {HALF{1'b0}}} +
                  {{HALF{1'b0}}, pp_hl_q, {HALF{1'b0}}};
      s2_tag_q <= s1_tag_q;
      s2_cmd_q <= s1_cmd_q;
      s3_data_q           <= s3_result;
      s3_flags_q.zero     <= (s3_result == '0);
      s3_flags_q.negative <= s3_result[XLEN-1];
      s3_flags_q.carry    <= 1'b0;
      s3_flags_q.overflow <= 1'b0;
      s3_tag_q <= s2_tag_q;
      s3_cmd_q <= s2_cmd_q;
    end
  end

  assign res_o.valid = s3_valid_q;
  assign res_o.data  = s3_data_q;
  assign res_o.tag   = s3_tag_q;
  assign res_o.cmd   = s3_cmd_q;
  assign res_o.flags = s3_flags_q;

endmodule

/* hdl/execute_output.sv */
module execute_output #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
) (
  exec_result_if.arbiter               mul_i,
  exec_result_if.arbiter               alu_i,
  output logic [exec_pkg::XLEN-1:0]    data_o,
  output logic [TAG_W-1:0]             tag_o,
  output exec_pkg::exec_cmd_t          cmd_o,
  output exec_pkg::exec_flags_t        flags_o,
  output logic                         valid_o
);

  // fixed priority, multiplier lane wins over the alu lane
  assign mul_i.can_go = mul_i.valid;
  assign alu_i.can_go = alu_i.valid && !mul_i.valid;

  // alu fields are the default when nothing is granted
  always_comb begin
    if (mul_i.can_go) begin
      data_o  = mul_i.data;
      tag_o   = mul_i.tag;
      cmd_o   = mul_i.cmd;
      flags_o = mul_i.flags;
    end else begin
      data_o  = alu_i.data;
      tag_o   = alu_i.tag;
      cmd_o   = alu_i.cmd;
      flags_o = alu_i.flags;
    end
  end

  // one result per cycle toward memory
  assign valid_o = mul_i.can_go | alu_i.can_go;

endmodule

/* hdl/execute_stage.sv */
module execute_stage #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // alu issue
  input  logic                       alu_valid_i,
  input  exec_pkg::exec_cmd_t        alu_cmd_i,
  input  logic [exec_pkg::XLEN-1:0]  alu_a_i,
  input  logic [exec_pkg::XLEN-1:0]  alu_b_i,
  input  logic [TAG_W-1:0]           alu_tag_i,
  output logic                       alu_ready_o,
  // multiplier issue
  input  logic                       mul_valid_i,
  input  exec_pkg::exec_cmd_t        mul_cmd_i,
  input  logic [exec_pkg::XLEN-1:0]  mul_a_i,
  input  logic [exec_pkg::XLEN-1:0]  mul_b_i,
  input  logic [TAG_W-1:0]           mul_tag_i,
  output logic                       mul_ready_o,
  // toward the memory stage
  output logic [exec_pkg::XLEN-1:0]  data_o,
  output logic [TAG_W-1:0]           tag_o,
  output exec_pkg::exec_cmd_t        cmd_o,
  output exec_pkg::exec_flags_t      flags_o,
  output logic                       valid_o
);

  // one result channel per unit
  exec_result_if #(.ROB_SIZE(ROB_SIZE)) alu_res ();
  exec_result_if #(.ROB_SIZE(ROB_SIZE)) mul_res ();

  alu_unit #(.ROB_SIZE(ROB_SIZE)) i_alu (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (alu_valid_i),
    .cmd_i   (alu_cmd_i),
    .a_i     (alu_a_i),
    .b_i     (alu_b_i),
    .tag_i   (alu_tag_i),
    .ready_o (alu_ready_o),
    .res_o   (alu_res.unit)
  );

  mul_unit #(.ROB_SIZE(ROB_SIZE)) i_mul (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mul_valid_i),
    .cmd_i   (mul_cmd_i),
    .a_i     (mul_a_i),
    .b_i     (mul_b_i),
    .tag_i   (mul_tag_i),
    .ready_o (mul_ready_o),
    .res_o   (mul_res.unit)
  );

  execute_output #(.ROB_SIZE(ROB_SIZE)) i_out (
    .mul_i   (mul_res.arbiter),
    .alu_i   (alu_res.arbiter),
    .data_o  (data_o),
    .tag_o   (tag_o),
    .cmd_o   (cmd_o),
    .flags_o (flags_o),
    .valid_o (valid_o)
  );

endmodule

/* verif/execute_stage_asserts.sv */
module execute_stage_asserts #(
  parameter int  ROB_SIZE = 32,
  localparam int TAG_W    = $clog2(ROB_SIZE + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       mul_valid_i,
  input  logic                       mul_go_i,
  input  logic                       alu_valid_i,
  input  logic                       alu_go_i,
  input  logic                       out_valid_i,
  input  logic [exec_pkg::XLEN-1:0]  alu_data_i,
  input  logic [TAG_W-1:0]           alu_tag_i
);

  // two lanes, so at most one-hot means never both
  grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mul_go_i && alu_go_i))
    else $error("both lanes granted in the same cycle");

  // a grant only goes to a lane with a result
  grant_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (!mul_go_i || mul_valid_i) && (!alu_go_i || alu_valid_i))
    else $error("grant on a lane without a valid result");

  out_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_i == (mul_go_i || alu_go_i))
    else $error("output valid differs from the OR of the grants");

  // waiting alu result must not move
  alu_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (alu_valid_i && !alu_go_i) |=> ($stable(alu_data_i) && $stable(alu_tag_i)))
    else $error("ungranted ALU result changed while waiting");

endmodule

/* verif/execute_stage_tb.sv */
module execute_stage_tb;
  import exec_pkg::*;

  localparam int ROB_SIZE   = 16;
  localparam int TAG_W      = $clog2(ROB_SIZE + 1);
  localparam int NUM_CYCLES = 2000;
  localparam int DRAIN_MAX  = 200;
  localparam int MUL_LAT    = 3;

  // one expected result with its issue cycle for the multiplier latency check
  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic [TAG_W-1:0]  tag;
    exec_cmd_t         cmd;
    exec_flags_t       flags;
    logic [31:0]       issue_cyc;
  } exp_entry_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              alu_valid;
  exec_cmd_t         alu_cmd;
  logic [XLEN-1:0]   alu_a;
  logic [XLEN-1:0]   alu_b;
  logic [TAG_W-1:0]  alu_tag;
  logic              alu_ready;
  logic              mul_valid;
  exec_cmd_t         mul_cmd;
  logic [XLEN-1:0]   mul_a;
  logic [XLEN-1:0]   mul_b;
  logic [TAG_W-1:0]  mul_tag;
  logic              mul_ready;
  logic [XLEN-1:0]   data_o;
  logic [TAG_W-1:0]  tag_o;
  exec_cmd_t         cmd_o;
  exec_flags_t       flags_o;
  logic              valid_o;

  // free running cycle count read at the falling edge
  logic [31:0]       cyc = '0;
  exp_entry_t        alu_q[$];
  exp_entry_t        mul_q[$];
  int                drain_cnt;

  execute_stage #(.ROB_SIZE(ROB_SIZE)) i_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .alu_valid_i (alu_valid),
    .alu_cmd_i   (alu_cmd),
    .alu_a_i     (alu_a),
    .alu_b_i     (alu_b),
    .alu_tag_i   (alu_tag),
    .alu_ready_o (alu_ready),
    .mul_valid_i (mul_valid),
    .mul_cmd_i   (mul_cmd),
    .mul_a_i     (mul_a),
    .mul_b_i     (mul_b),
    .mul_tag_i   (mul_tag),
    .mul_ready_o (mul_ready),
    .data_o      (data_o),
    .tag_o       (tag_o),
    .cmd_o       (cmd_o),
    .flags_o     (flags_o),
    .valid_o     (valid_o)
  );

  // grant and hold checks sit inside the arbiter
  bind execute_output execute_stage_asserts #(.ROB_SIZE(ROB_SIZE)) i_asserts (
    .clk_i       (execute_stage_tb.clk),
    .rst_i       (execute_stage_tb.rst),
    .mul_valid_i (mul_i.valid),
    .mul_go_i    (mul_i.can_go),
    .alu_valid_i (alu_i.valid),
    .alu_go_i    (alu_i.can_go),
    .out_valid_i (valid_o),
    .alu_data_i  (alu_i.data),
    .alu_tag_i   (alu_i.tag)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(string what);
    $display("time %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_data(string name, logic [XLEN-1:0] want, logic [XLEN-1:0] got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %h actual %h", $time, name, want, got);
      stop_run();
    end
  endtask

  task automatic check_tag(string name, logic [TAG_W-1:0] want, logic [TAG_W-1:0] got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %h actual %h", $time, name, want, got);
      stop_run();
    end
  endtask

  task automatic check_cmd(string name, exec_cmd_t want, exec_cmd_t got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %h actual %h", $time, name, want, got);
      stop_run();
    end
  endtask

  task automatic check_flags(string name, exec_flags_t want, exec_flags_t got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %b actual %b", $time, name, want, got);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic want, logic got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %b actual %b", $time, name, want, got);
      stop_run();
    end
  endtask

  task automatic check_latency(string name, logic [31:0] want, logic [31:0] got);
    if (got !== want) begin
      $display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, want, got);
      stop_run();
    end
  endtask

  // alu results with carry and overflow only for add and sub
  // sub carry set means no borrow
  function automatic exp_entry_t model_alu(exec_cmd_t cmd, logic [XLEN-1:0] a,
                                           logic [XLEN-1:0] b, logic [TAG_W-1:0] tag);
    exp_entry_t    e;
    logic [XLEN:0] wide;
    e     = '0;
    e.tag = tag;
    e.cmd = cmd;
    case (cmd.op)
      OP_ADD: begin
        wide             = {1'b0, a} + {1'b0, b};
        e.data           = wide[XLEN-1:0];
        e.flags.carry    = wide[XLEN];
        e.flags.overflow = (a[XLEN-1] == b[XLEN-1]) && (e.data[XLEN-1] != a[XLEN-1]);
      end
      OP_SUB: begin
        e.data           = a - b;
        e.flags.carry    = (a >= b);
        e.flags.overflow = (a[XLEN-1] != b[XLEN-1]) && (e.data[XLEN-1] != a[XLEN-1]);
      end
      OP_AND:  e.data = a & b;
      OP_OR:   e.data = a | b;
      OP_XOR:  e.data = a ^ b;
      OP_SLL:  e.data = a << b[5:0];
      OP_SRL:  e.data = a >> b[5:0];
      OP_SLT:  e.data = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
      default: e.data = '0;
    endcase
    e.flags.zero     = (e.data == '0);
    e.flags.negative = e.data[XLEN-1];
    return e;
  endfunction

  // unsigned 128-bit product with the half picked by the opcode
  function automatic exp_entry_t model_mul(exec_cmd_t cmd, logic [XLEN-1:0] a,
                                           logic [XLEN-1:0] b, logic [TAG_W-1:0] tag);
    exp_entry_t        e;
    logic [2*XLEN-1:0] prod;
    e                = '0;
    e.tag            = tag;
    e.cmd            = cmd;
    prod             = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    e.data           = (cmd.op == OP_MULHU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    e.flags.zero     = (e.data == '0);
    e.flags.negative = e.data[XLEN-1];
    return e;
  endfunction

  // corner values now and then so zero, sign and overflow get hit
  function automatic logic [XLEN-1:0] random_operand();
    logic [XLEN-1:0] v;
    case ($urandom_range(0, 7))
      0:       v = '0;
      1:       v = '1;
      2:       v = {1'b1, {(XLEN-1){1'b0}}};
      3:       v = XLEN'($urandom_range(0, 255));
      default: v = {$urandom, $urandom};
    endcase
    return v;
  endfunction

  function automatic exec_cmd_t random_cmd(logic for_mul);
    exec_cmd_t cmd;
    if (for_mul) begin
      cmd.op = ($urandom_range(0, 1) == 0) ? OP_MUL : OP_MULHU;
    end else begin
      cmd.op = exec_op_e'(4'($urandom_range(0, 7)));
    end
    cmd.mem_op = mem_op_e'(2'($urandom_range(0, 2)));
    cmd.rd     = RD_W'($urandom_range(0, 15));
    return cmd;
  endfunction

  task automatic drive_random_issue();
    alu_valid <= ($urandom_range(0, 9) < 7);
    alu_cmd   <= random_cmd(1'b0);
    alu_a     <= random_operand();
    alu_b     <= random_operand();
    alu_tag   <= TAG_W'($urandom_range(0, ROB_SIZE - 1));
    mul_valid <= ($urandom_range(0, 9) < 4);
    mul_cmd   <= random_cmd(1'b1);
    mul_a     <= random_operand();
    mul_b     <= random_operand();
    mul_tag   <= TAG_W'($urandom_range(0, ROB_SIZE - 1));
  endtask

  task automatic compare_entry(exp_entry_t want);
    check_data("data_o", want.data, data_o);
    check_tag("tag_o", want.tag, tag_o);
    check_cmd("cmd_o", want.cmd, cmd_o);
    check_flags("flags_o", want.flags, flags_o);
  endtask

  // opcode on the output names the queue to pop
  task automatic check_result();
    exp_entry_t want;
    if (cmd_o.op == OP_MUL || cmd_o.op == OP_MULHU) begin
      if (mul_q.size() == 0) begin
        report_error("multiplier result on valid_o with no multiplier operation outstanding");
      end else begin
        want = mul_q.pop_front();
        check_latency("mul issue to valid_o", MUL_LAT, cyc - want.issue_cyc);
        compare_entry(want);
      end
    end else if (cmd_o.op <= OP_SLT) begin
      if (alu_q.size() == 0) begin
        report_error("ALU result on valid_o with no ALU operation outstanding");
      end else begin
        want = alu_q.pop_front();
        compare_entry(want);
      end
    end else begin
      report_error("valid_o carries an opcode that neither unit executes");
    end
  endtask

  // an issue counts only when strobe and ready meet at the coming edge
  task automatic record_issues();
    exp_entry_t e;
    if (alu_valid && alu_ready) begin
      e           = model_alu(alu_cmd, alu_a, alu_b, alu_tag);
      e.issue_cyc = cyc;
      alu_q.push_back(e);
    end
    if (mul_valid && mul_ready) begin
      e           = model_mul(mul_cmd, mul_a, mul_b, mul_tag);
      e.issue_cyc = cyc;
      mul_q.push_back(e);
    end
  endtask

  // outputs and readies are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (valid_o === 1'b1) begin
        check_result();
      end else if (valid_o !== 1'b0) begin
        report_error("valid_o is unknown after reset");
      end
      record_issues();
    end
  end

  initial begin
    void'($urandom(32'h1f66abbf));
    rst       <= 1'b1;
    alu_valid <= 1'b0;
    alu_cmd   <= '0;
    alu_a     <= '0;
    alu_b     <= '0;
    alu_tag   <= '0;
    mul_valid <= 1'b0;
    mul_cmd   <= '0;
    mul_a     <= '0;
    mul_b     <= '0;
    mul_tag   <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // idle after reset with nothing out and both units open
    repeat (3) begin
      @(negedge clk);
      check_bit("valid_o", 1'b0, valid_o);
      check_bit("alu_ready_o", 1'b1, alu_ready);
      check_bit("mul_ready_o", 1'b1, mul_ready);
    end
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      drive_random_issue();
    end
    @(posedge clk);
    alu_valid <= 1'b0;
    mul_valid <= 1'b0;
    drain_cnt = 0;
    while ((alu_q.size() != 0 || mul_q.size() != 0) && drain_cnt < DRAIN_MAX) begin
      @(posedge clk);
      drain_cnt++;
    end
    if (alu_q.size() == 0 && mul_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      if (alu_q.size() != 0) begin
        $display("ALU queue still holds %0d results after the drain", alu_q.size());
      end
      if (mul_q.size() != 0) begin
        $display("multiplier queue still holds %0d results after the drain", mul_q.size());
      end
      stop_run();
    end
  end

endmodule

/* tb.f */
hdl/exec_pkg.sv
hdl/exec_result_if.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/execute_output.sv
hdl/execute_stage.sv
verif/execute_stage_asserts.sv
verif/execute_stage_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR  := verilator
TOP        := execute_stage_tb
FILELIST   := tb.f
MDIR       := obj_dir
VFLAGS     := --timing --assert --top-module $(TOP)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 --Mdir $(MDIR)

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST)

$(MDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation binary is the test result
sim: $(MDIR)/V$(TOP)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
